// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_periph
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)

// File: board_io.sv
//**********************************************************
// Board IO
// Status LED register and a mock gamepad built from the
// three board buttons, read out through a shift register
//**********************************************************

`default_nettype none
`timescale 1ns/1ps

`include "periph_cfg.svh"

module board_io (
    input  logic         vdp_clk,
    input  logic         vdp_reset,

    periph_bus_if.periph bus,

    input  logic         btn_1,
    input  logic         btn_2,
    input  logic         btn_3,

    output logic         led_r,
    output logic         led_b,

    output logic         pad_bit
);

    logic [1:0]           status;
    logic                 pad_latch;
    logic                 pad_clk;
    logic                 pad_clk_r;
    logic                 pad_shift;
    logic [`PAD_BITS-1:0] pad_state;

    // LEDs
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= `STATUS_RESET;
        end else if (bus.status_we) begin
            status <= bus.wdata.raw[1:0];
        end
    end

    assign led_r = status[0];
    assign led_b = status[1];

    // Pad control, both bits driven by software
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_latch <= 1'b0;
            pad_clk   <= 1'b0;
            pad_clk_r <= 1'b0;
        end else begin
            if (bus.pad_we) begin
                pad_latch <= bus.wdata.raw[0];
                pad_clk   <= bus.wdata.raw[1];
            end
            pad_clk_r <= pad_clk;
        end
    end

    // Rising edge of the software pad clock
    assign pad_shift = pad_clk && !pad_clk_r;

    // B, right and left land where a real pad reports them
    always_ff @(posedge vdp_clk) begin
        if (pad_latch) begin
            pad_state <= {{(`PAD_BITS-8){1'b0}}, btn_1, btn_3, 5'b0, btn_2};
        end

        if (pad_shift) begin
            pad_state <= {1'b0, pad_state[`PAD_BITS-1:1]};
        end
    end

    assign pad_bit = pad_state[0];

    a_latch_or_shift: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset)
        !(pad_latch && pad_shift)
    );

endmodule

`default_nettype wire

// File: bus_decoder.sv
//**********************************************************
// Bus decoder
// Decodes the host address into peripheral write strobes,
// registers the read data by region and returns ready
//**********************************************************

`default_nettype none
`timescale 1ns/1ps

`include "periph_cfg.svh"

module bus_decoder (
    input  logic                         vdp_clk,
    input  logic                         vdp_reset,

    input  logic [`PERIPH_ADDR_W-1:0]    address,
    input  logic [`PERIPH_DATA_W-1:0]    write_data,
    input  logic [`PERIPH_DATA_W/8-1:0]  wstrb,
    input  logic                         valid,
    output logic                         ready,
    output logic [`PERIPH_DATA_W-1:0]    read_data,

    periph_bus_if.dec                    bus,

    input  logic [`PERIPH_DATA_W-1:0]    dsp_result,
    input  logic                         pad_bit,
    input  logic [`FLASH_IO_W-1:0]       flash_sample
);

    logic [`REGION_MSB-`REGION_LSB:0] region;
    logic                             accept;
    logic                             wr_accept;
    logic [`PERIPH_DATA_W-1:0]        read_mux;

    assign region = address[`REGION_MSB:`REGION_LSB];

    // Host keeps valid up through the ready cycle, so ready doubles as busy
    assign accept    = valid && !ready;
    assign wr_accept = accept && (|wstrb);

    assign bus.wdata   = periph_pkg::bus_word_t'(write_data);
    assign bus.reg_sel = address[2];

    assign bus.status_we = wr_accept && (region == `REGION_STATUS);
    assign bus.dsp_we    = wr_accept && (region == `REGION_DSP);
    assign bus.pad_we    = wr_accept && (region == `REGION_PAD);
    assign bus.flash_we  = wr_accept && (region == `REGION_FLASH);

    // Read source by region
    always_comb begin
        case (region)
            `REGION_DSP: begin
                read_mux = dsp_result;
            end
            `REGION_PAD: begin
                read_mux = {{(`PERIPH_DATA_W-1){1'b0}}, pad_bit};
            end
            `REGION_FLASH: begin
                read_mux = {{(`PERIPH_DATA_W-`FLASH_IO_W){1'b0}}, flash_sample};
            end
            default: begin
                // Status has no read-back, unmapped reads as zero
                read_mux = '0;
            end
        endcase
    end

    // Access completes the cycle after it was accepted
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            ready <= 1'b0;
        end else begin
            ready <= accept;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (accept) begin
            read_data <= read_mux;
        end
    end

    // Request held steady by the host until ready
    a_host_holds: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset)
        valid && !ready |=> valid && $stable(address) && $stable(write_data)
            && $stable(wstrb)
    );

    // Valid dropped after ready, or the same request would be taken twice
    a_host_releases: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset)
        ready |=> !valid
    );

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
periph_pkg.sv
periph_bus_if.sv
bus_decoder.sv
mul_unit.sv
board_io.sv
flash_port.sv
periph_top.sv
tb_periph.sv

// File: flash_port.sv
//**********************************************************
// Flash port
// Bit-banged flash control register driving the flash pins,
// with a sampled copy of the flash data outputs
//**********************************************************

`default_nettype none
`timescale 1ns/1ps

`include "periph_cfg.svh"

module flash_port (
    input  logic                   vdp_clk,
    input  logic                   vdp_reset,

    periph_bus_if.periph           bus,

    input  logic [`FLASH_IO_W-1:0] flash_out,
    output logic [`FLASH_IO_W-1:0] flash_sample,

    output logic                   flash_clk,
    output logic                   flash_csn,
    output logic [`FLASH_IO_W-1:0] flash_in,
    output logic [`FLASH_IO_W-1:0] flash_in_en
);

    logic                   ctrl_active;
    logic                   ctrl_csn;
    logic                   ctrl_clk;
    logic [`FLASH_IO_W-1:0] ctrl_in_en;
    logic [`FLASH_IO_W-1:0] ctrl_in;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            ctrl_active <= 1'b0;
            ctrl_csn    <= 1'b1;
            ctrl_clk    <= 1'b0;
            ctrl_in_en  <= '0;
        end else if (bus.flash_we) begin
            ctrl_active <= bus.wdata.flash_ctrl.active;
            ctrl_csn    <= bus.wdata.flash_ctrl.csn;
            ctrl_clk    <= bus.wdata.flash_ctrl.clk;
            ctrl_in_en  <= bus.wdata.flash_ctrl.in_en;
        end
    end

    // Data driven towards the flash data pins
    always_ff @(posedge vdp_clk) begin
        if (bus.flash_we) begin
            ctrl_in <= bus.wdata.flash_ctrl.in;
        end
    end

    // Pins idle with the chip deselected when software lets go
    assign flash_csn   = ctrl_active ? ctrl_csn : 1'b1;
    assign flash_clk   = ctrl_active ? ctrl_clk : 1'b0;
    assign flash_in_en = ctrl_active ? ctrl_in_en : '0;
    assign flash_in    = ctrl_active ? ctrl_in : '0;

    // Read-back of the data pins
    always_ff @(posedge vdp_clk) begin
        flash_sample <= flash_out;
    end

endmodule

`default_nettype wire

// File: mul_unit.sv
//**********************************************************
// Multiplier unit
// Two operand registers and a registered signed product
//**********************************************************

`default_nettype none
`timescale 1ns/1ps

`include "periph_cfg.svh"

module mul_unit (
    input  logic                      vdp_clk,

    periph_bus_if.periph              bus,

    output logic [`PERIPH_DATA_W-1:0] dsp_result
);

    logic signed [`MUL_W-1:0] mul_a;
    logic signed [`MUL_W-1:0] mul_b;

    // Operand A at reg_sel 0, operand B at reg_sel 1
    always_ff @(posedge vdp_clk) begin
        if (bus.dsp_we && !bus.reg_sel) begin
            mul_a <= bus.wdata.raw[`MUL_W-1:0];
        end

        if (bus.dsp_we && bus.reg_sel) begin
            mul_b <= bus.wdata.raw[`MUL_W-1:0];
        end
    end

    // Product follows the operands with one cycle of latency
    always_ff @(posedge vdp_clk) begin
        dsp_result <= mul_a * mul_b;
    end

endmodule

`default_nettype wire

// File: periph_bus_if.sv
//**********************************************************
// Peripheral bus interface
// Write word, register select and one-cycle write strobes
// from the address decoder to the peripherals
//**********************************************************

`default_nettype none
`timescale 1ns/1ps

interface periph_bus_if;

    periph_pkg::bus_word_t wdata;

    // Address bit 2, picks between two registers in a region
    logic reg_sel;

    // One strobe per region, high for a single cycle
    logic status_we;
    logic dsp_we;
    logic pad_we;
    logic flash_we;

    modport dec (
        output wdata, reg_sel, status_we, dsp_we, pad_we, flash_we
    );

    modport periph (
        input wdata, reg_sel, status_we, dsp_we, pad_we, flash_we
    );

endinterface

`default_nettype wire

// File: periph_cfg.svh
//**********************************************************
// Peripheral configuration
// Bus widths, the peripheral address map and reset values
// shared by the decoder and the peripheral blocks
//**********************************************************

`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// Host bus
`define PERIPH_ADDR_W 24
`define PERIPH_DATA_W 32

// Region field of the address, selects one peripheral
`define REGION_MSB 19
`define REGION_LSB 16

// Region codes
`define REGION_STATUS 4'd1
`define REGION_DSP    4'd2
`define REGION_PAD    4'd3
`define REGION_FLASH  4'd4

// Multiplier operand width
`define MUL_W 16

// Gamepad shift register length
`define PAD_BITS 16

// Flash data pins (quad IO)
`define FLASH_IO_W 4

// LED value after reset, red on
`define STATUS_RESET 2'b01

`endif

// File: periph_input.txt
# Each record holds op name address data buttons flash_out expected
# Numbers are hex and buttons hold btn_1 in bit 0, btn_2 in bit 1, btn_3 in bit 2
# Pin checks expect csn, clk, in_en and in in the flash control bit layout
leds  reset_leds    000000 00000000 0 0 00000001
pins  reset_pins    000000 00000000 0 0 00000200
write status_write  010000 00000002 0 0 00000000
leds  status_leds   000000 00000000 0 0 00000002
write mul_a_neg     020000 0000fffd 0 0 00000000
write mul_b_pos     020004 00001234 0 0 00000000
read  mul_neg_pos   020000 00000000 0 0 ffffc964
write mul_a_min     020000 00008000 0 0 00000000
write mul_b_min     020004 00008000 0 0 00000000
read  mul_min_min   020000 00000000 0 0 40000000
write pad_latch_on  030000 00000001 6 0 00000000
write pad_latch_off 030000 00000000 6 0 00000000
read  pad_shift_0   030000 00000000 6 0 00000001
pulse pad_clock_1   030000 00000002 6 0 00000000
read  pad_shift_1   030000 00000000 6 0 00000000
pulse pad_clock_2   030000 00000002 6 0 00000000
pulse pad_clock_3   030000 00000002 6 0 00000000
pulse pad_clock_4   030000 00000002 6 0 00000000
pulse pad_clock_5   030000 00000002 6 0 00000000
pulse pad_clock_6   030000 00000002 6 0 00000000
read  pad_shift_6   030000 00000000 6 0 00000001
pulse pad_clock_7   030000 00000002 6 0 00000000
read  pad_shift_7   030000 00000000 6 0 00000000
write flash_on      040000 000081fa 0 0 00000000
pins  flash_active  000000 00000000 0 0 000001fa
write flash_off     040000 000001fa 0 0 00000000
pins  flash_idle    000000 00000000 0 0 00000200
read  flash_sample  040000 00000000 0 9 00000009
read  unmapped      050000 00000000 0 0 00000000

// File: periph_pkg.sv
//**********************************************************
// Peripheral package
// Bus word type with the raw view and the decoded flash
// control view of the same write word
//**********************************************************

`default_nettype none

`include "periph_cfg.svh"

package periph_pkg;

    // Flash control word, bit 15 hands the pins to the CPU
    typedef struct packed {
        logic [`PERIPH_DATA_W-17:0] reserved_hi;
        logic                       active;
        logic [4:0]                 reserved_lo;
        logic                       csn;
        logic                       clk;
        logic [`FLASH_IO_W-1:0]     in_en;
        logic [`FLASH_IO_W-1:0]     in;
    } flash_ctrl_t;

    // Write word as seen by the peripherals
    typedef union packed {
        logic [`PERIPH_DATA_W-1:0] raw;
        flash_ctrl_t               flash_ctrl;
    } bus_word_t;

endpackage

`default_nettype wire

// File: periph_top.sv
//**********************************************************
// Peripheral top level
// Host bus decoder plus LED, multiplier, gamepad and flash
// control peripherals behind plain board-level ports
//**********************************************************

`default_nettype none
`timescale 1ns/1ps

`include "periph_cfg.svh"

module periph_top (
    input  logic                         vdp_clk,
    input  logic                         vdp_reset,

    // Host bus
    input  logic [`PERIPH_ADDR_W-1:0]    address,
    input  logic [`PERIPH_DATA_W-1:0]    write_data,
    input  logic [`PERIPH_DATA_W/8-1:0]  wstrb,
    input  logic                         valid,
    output logic                         ready,
    output logic [`PERIPH_DATA_W-1:0]    read_data,

    // Board buttons and LEDs
    input  logic                         btn_1,
    input  logic                         btn_2,
    input  logic                         btn_3,
    output logic                         led_r,
    output logic                         led_b,

    // Flash pins
    output logic                         flash_clk,
    output logic                         flash_csn,
    output logic [`FLASH_IO_W-1:0]       flash_in,
    output logic [`FLASH_IO_W-1:0]       flash_in_en,
    input  logic [`FLASH_IO_W-1:0]       flash_out
);

    logic [`PERIPH_DATA_W-1:0] dsp_result;
    logic                      pad_bit;
    logic [`FLASH_IO_W-1:0]    flash_sample;

    periph_bus_if bus_if ();

    bus_decoder decoder (
        .vdp_clk      (vdp_clk),
        .vdp_reset    (vdp_reset),
        .address      (address),
        .write_data   (write_data),
        .wstrb        (wstrb),
        .valid        (valid),
        .ready        (ready),
        .read_data    (read_data),
        .bus          (bus_if.dec),
        .dsp_result   (dsp_result),
        .pad_bit      (pad_bit),
        .flash_sample (flash_sample)
    );

    mul_unit mul (
        .vdp_clk    (vdp_clk),
        .bus        (bus_if.periph),
        .dsp_result (dsp_result)
    );

    board_io board (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .bus       (bus_if.periph),
        .btn_1     (btn_1),
        .btn_2     (btn_2),
        .btn_3     (btn_3),
        .led_r     (led_r),
        .led_b     (led_b),
        .pad_bit   (pad_bit)
    );

    flash_port flash (
        .vdp_clk      (vdp_clk),
        .vdp_reset    (vdp_reset),
        .bus          (bus_if.periph),
        .flash_out    (flash_out),
        .flash_sample (flash_sample),
        .flash_clk    (flash_clk),
        .flash_csn    (flash_csn),
        .flash_in     (flash_in),
        .flash_in_en  (flash_in_en)
    );

endmodule

`default_nettype wire

// File: tb_periph.sv
//**********************************************************
// Peripheral testbench
// Replays bus cycles and board levels from the input file
// and checks read data, LEDs and flash pins
//**********************************************************

`default_nettype none
`timescale 1ns/1ps

`include "periph_cfg.svh"

module tb_periph;

    localparam int READY_TIMEOUT = 16;

    logic                        vdp_clk;
    logic                        vdp_reset;
    logic [`PERIPH_ADDR_W-1:0]   address;
    logic [`PERIPH_DATA_W-1:0]   write_data;
    logic [`PERIPH_DATA_W/8-1:0] wstrb;
    logic                        valid;
    logic                        ready;
    logic [`PERIPH_DATA_W-1:0]   read_data;
    logic                        btn_1;
    logic                        btn_2;
    logic                        btn_3;
    logic                        led_r;
    logic                        led_b;
    logic                        flash_clk;
    logic                        flash_csn;
    logic [`FLASH_IO_W-1:0]      flash_in;
    logic [`FLASH_IO_W-1:0]      flash_in_en;
    logic [`FLASH_IO_W-1:0]      flash_out;

    periph_top DUT (
        .vdp_clk     (vdp_clk),
        .vdp_reset   (vdp_reset),
        .address     (address),
        .write_data  (write_data),
        .wstrb       (wstrb),
        .valid       (valid),
        .ready       (ready),
        .read_data   (read_data),
        .btn_1       (btn_1),
        .btn_2       (btn_2),
        .btn_3       (btn_3),
        .led_r       (led_r),
        .led_b       (led_b),
        .flash_clk   (flash_clk),
        .flash_csn   (flash_csn),
        .flash_in    (flash_in),
        .flash_in_en (flash_in_en),
        .flash_out   (flash_out)
    );

    initial begin
        vdp_clk = 1'b0;
        forever begin
            #50 vdp_clk = ~vdp_clk;
        end
    end

    task automatic stop_on_failure();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_word(input string name, input periph_pkg::bus_word_t expected,
                              input periph_pkg::bus_word_t actual);
        if (actual !== expected) begin
            $display("Error %s: expected %h, actual %h", name, expected.raw, actual.raw);
            stop_on_failure();
        end
    endtask

    task automatic check_leds(input string name, input logic [1:0] expected,
                              input logic [1:0] actual);
        if (actual !== expected) begin
            $display("Error %s: expected %b, actual %b", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_flash_pins(input string name, input periph_pkg::flash_ctrl_t expected,
                                    input periph_pkg::flash_ctrl_t actual);
        if (actual !== expected) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    // One host access, valid held until ready then dropped for a cycle
    task automatic bus_access(input logic is_write, input logic [`PERIPH_ADDR_W-1:0] addr,
                              input logic [`PERIPH_DATA_W-1:0] data,
                              output periph_pkg::bus_word_t rdata);
        int waited;
        waited = 0;
        @(posedge vdp_clk);
        address    <= addr;
        write_data <= data;
        wstrb      <= {(`PERIPH_DATA_W/8){is_write}};
        valid      <= 1'b1;
        @(negedge vdp_clk);
        while (!ready) begin
            if (waited == READY_TIMEOUT) begin
                $display("The DUT gave no ready within %0d cycles", READY_TIMEOUT);
                stop_on_failure();
            end
            waited++;
            @(negedge vdp_clk);
        end
        rdata = read_data;
        @(posedge vdp_clk);
        valid <= 1'b0;
        wstrb <= '0;
    endtask

    initial begin
        int                        fd;
        int                        fields;
        int                        records;
        string                     line;
        string                     op;
        string                     name;
        logic [`PERIPH_ADDR_W-1:0] addr;
        logic [`PERIPH_DATA_W-1:0] data;
        logic [2:0]                btns;
        logic [`FLASH_IO_W-1:0]    fo;
        logic [`PERIPH_DATA_W-1:0] expected;
        periph_pkg::bus_word_t     rdata;
        periph_pkg::flash_ctrl_t   pins;

        vdp_reset  = 1'b1;
        address    = '0;
        write_data = '0;
        wstrb      = '0;
        valid      = 1'b0;
        btn_1      = 1'b0;
        btn_2      = 1'b0;
        btn_3      = 1'b0;
        flash_out  = '0;
        records    = 0;

        fd = $fopen("periph_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open periph_input.txt");
            stop_on_failure();
        end

        repeat (5) @(posedge vdp_clk);
        vdp_reset <= 1'b0;

        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Skip blank lines and column notes
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
                fields = $sscanf(line, "%s %s %h %h %h %h %h",
                                 op, name, addr, data, btns, fo, expected);
                if (fields != 7) begin
                    $display("Malformed record in the input file: %s", line);
                    stop_on_failure();
                end

                // Board levels settle a cycle ahead of the access
                @(posedge vdp_clk);
                btn_1     <= btns[0];
                btn_2     <= btns[1];
                btn_3     <= btns[2];
                flash_out <= fo;

                if (op == "write") begin
                    bus_access(1'b1, addr, data, rdata);
                end else if (op == "pulse") begin
                    bus_access(1'b1, addr, data, rdata);
                    bus_access(1'b1, addr, '0, rdata);
                end else if (op == "read") begin
                    bus_access(1'b0, addr, data, rdata);
                    check_word(name, periph_pkg::bus_word_t'(expected), rdata);
                end else if (op == "leds") begin
                    @(negedge vdp_clk);
                    check_leds(name, expected[1:0], {led_b, led_r});
                end else if (op == "pins") begin
                    @(negedge vdp_clk);
                    pins       = '0;
                    pins.csn   = flash_csn;
                    pins.clk   = flash_clk;
                    pins.in_en = flash_in_en;
                    pins.in    = flash_in;
                    check_flash_pins(name, periph_pkg::flash_ctrl_t'(expected), pins);
                end else begin
                    $display("Unknown operation %s in the input file", op);
                    stop_on_failure();
                end
                records++;
            end
        end
        $fclose(fd);

        if (records == 0) begin
            $display("The input file held no records");
            stop_on_failure();
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
